// File: Makefile
.PHONY: all run clean

all: run

obj_dir/Vtb_oddpipe: verilog.f oddpipe_pkg.sv oddpipe_issue.sv oddpipe_permute.sv \
		oddpipe_branch.sv oddpipe_forward.sv oddpipe_top.sv tb_oddpipe.sv
	verilator --binary --timing --assert -Wno-fatal --top-module tb_oddpipe \
		-f verilog.f -o Vtb_oddpipe

run: obj_dir/Vtb_oddpipe
	@out="$$(./obj_dir/Vtb_oddpipe)"; echo "$$out"; \
		echo "$$out" | grep -qx 'ALL CHECKS PASSED'

clean:
	rm -rf obj_dir

// File: oddpipe_branch.sv
`timescale 1ns/1ps

module oddpipe_branch #(
    parameter logic [0:31] LS_ADDR_MASK = 32'h0003_FFFF
) (
    input  oddpipe_pkg::exec_t     exec,
    output oddpipe_pkg::quad_t     branch_link,
    output oddpipe_pkg::redirect_t branch_redirect
);
    import oddpipe_pkg::*;

    logic [0:31] rb_word;
    logic [0:15] rb_half;
    logic [0:31] next_pc;
    logic [0:31] target;
    logic        conditional;
    logic        cond_met;

    // conditions look at the preferred slot of rb
    assign rb_word = exec.rb[0:31];
    assign rb_half = exec.rb[16:31];

    assign next_pc = (exec.pc + 32'd4) & LS_ADDR_MASK;
    assign target  = (exec.absolute ? exec.disp : exec.pc + exec.disp) & LS_ADDR_MASK;

    always_comb
    begin
        conditional = 1'b1;
        case (exec.branch_kind)
            BR_IF_ZERO_WORD: cond_met = (rb_word == '0);
            BR_IF_NZ_WORD:   cond_met = (rb_word != '0);
            BR_IF_ZERO_HALF: cond_met = (rb_half == '0);
            BR_IF_NZ_HALF:   cond_met = (rb_half != '0);
            default:
            begin
                conditional = 1'b0;
                cond_met    = 1'b1;
            end
        endcase
    end

    always_comb
    begin
        branch_redirect.taken = cond_met;
        if (!cond_met)
        begin
            // fall through to the next instruction
            branch_redirect.target = next_pc;
        end
        else if (conditional)
        begin
            branch_redirect.target = target & 32'hFFFF_FFFC;
        end
        else
        begin
            branch_redirect.target = target;
        end
    end

    // return address in word 0, only for the set-link forms
    assign branch_link = (exec.branch_kind == BR_SET_LINK) ? {next_pc, 96'd0} : '0;

endmodule

// File: oddpipe_forward.sv
`timescale 1ns/1ps

module oddpipe_forward #(
    parameter int unsigned FW_STAGES = 7
) (
    input  logic                                  clock,
    input  logic                                  reset,
    input  oddpipe_pkg::exec_t                    exec,
    input  oddpipe_pkg::quad_t                    perm_result,
    input  oddpipe_pkg::quad_t                    branch_link,
    input  oddpipe_pkg::redirect_t                branch_redirect,
    output oddpipe_pkg::fw_entry_t [1:FW_STAGES]  fw_stages,
    output oddpipe_pkg::redirect_t                redirect
);
    import oddpipe_pkg::*;

    fw_entry_t entry;
    logic      is_branch;

    assign is_branch = exec.valid && exec.unit == UNIT_BRANCH;

    // idle cycles and nops retire as an empty record
    always_comb
    begin
        entry = '0;
        if (exec.valid && exec.unit == UNIT_PERM)
        begin
            entry.unit_id  = PERM_UNIT_ID;
            entry.rt_value = perm_result;
            entry.wr_en    = 1'b1;
            entry.rt       = exec.rt;
            entry.latency  = PERM_LATENCY;
        end
        else if (is_branch)
        begin
            entry.unit_id  = BRANCH_UNIT_ID;
            entry.rt_value = branch_link;
            entry.wr_en    = (exec.branch_kind == BR_SET_LINK);
            entry.rt       = exec.rt;
            entry.latency  = BRANCH_LATENCY;
        end
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            fw_stages <= '0;
            redirect  <= '0;
        end
        else
        begin
            fw_stages[1] <= entry;
            for (int k = 2; k <= FW_STAGES; k++)
            begin
                fw_stages[k] <= fw_stages[k - 1];
            end
            redirect <= is_branch ? branch_redirect : '0;
        end
    end

    // the record takes branch_link for every branch kind and must hold zero without a link
    a_link_only_set_link: assert property (@(posedge clock) disable iff (reset)
        is_branch && exec.branch_kind != BR_SET_LINK |-> branch_link == '0);

endmodule

// File: oddpipe_issue.sv
`timescale 1ns/1ps

module oddpipe_issue (
    input  logic                clock,
    input  logic                reset,
    input  oddpipe_pkg::issue_t issue,
    output oddpipe_pkg::exec_t  exec
);
    import oddpipe_pkg::*;

    exec_t dec;

    always_comb
    begin
        dec             = '0;
        dec.valid       = issue.valid;
        dec.ra          = issue.ra;
        dec.rb          = issue.rb;
        dec.rt          = issue.rt;
        dec.pc          = issue.pc;
        dec.disp        = {{14{issue.i16[0]}}, issue.i16, 2'b00};
        dec.unit        = UNIT_PERM;
        dec.perm_mode   = PERM_SHL_BITS;
        dec.branch_kind = BR_ALWAYS;

        // count field depends on the form of the instruction
        case (issue.opcode)
            OP_SHLQBI:  dec.shift_count = {2'b00, issue.rb[29:31]};
            OP_SHLQBII: dec.shift_count = {2'b00, issue.i7[4:6]};
            OP_SHLQBY:
            begin
                dec.perm_mode   = PERM_SHL_BYTES;
                dec.shift_count = issue.rb[27:31];
            end
            OP_SHLQBYI:
            begin
                dec.perm_mode   = PERM_SHL_BYTES;
                dec.shift_count = issue.i7[2:6];
            end
            OP_SHLQBYB:
            begin
                dec.perm_mode   = PERM_SHL_BYTES;
                dec.shift_count = issue.rb[24:28];
            end
            OP_ROTQBI:
            begin
                dec.perm_mode   = PERM_ROT_BITS;
                dec.shift_count = {2'b00, issue.rb[29:31]};
            end
            OP_ROTQBII:
            begin
                dec.perm_mode   = PERM_ROT_BITS;
                dec.shift_count = {2'b00, issue.i7[4:6]};
            end
            OP_ROTQBY:
            begin
                dec.perm_mode   = PERM_ROT_BYTES;
                dec.shift_count = {1'b0, issue.rb[28:31]};
            end
            OP_ROTQBYI:
            begin
                dec.perm_mode   = PERM_ROT_BYTES;
                dec.shift_count = {1'b0, issue.i7[3:6]};
            end
            OP_ROTQBYB:
            begin
                dec.perm_mode   = PERM_ROT_BYTES;
                dec.shift_count = issue.rb[24:28];
            end
            OP_GBB: dec.perm_mode = PERM_GATHER_BYTE;
            OP_GBH: dec.perm_mode = PERM_GATHER_HALF;
            OP_GB:  dec.perm_mode = PERM_GATHER_WORD;
            OP_BR:  dec.unit = UNIT_BRANCH;
            OP_BRA:
            begin
                dec.unit     = UNIT_BRANCH;
                dec.absolute = 1'b1;
            end
            OP_BRSL:
            begin
                dec.unit        = UNIT_BRANCH;
                dec.branch_kind = BR_SET_LINK;
            end
            OP_BRASL:
            begin
                dec.unit        = UNIT_BRANCH;
                dec.branch_kind = BR_SET_LINK;
                dec.absolute    = 1'b1;
            end
            OP_BRZ:
            begin
                dec.unit        = UNIT_BRANCH;
                dec.branch_kind = BR_IF_ZERO_WORD;
            end
            OP_BRNZ:
            begin
                dec.unit        = UNIT_BRANCH;
                dec.branch_kind = BR_IF_NZ_WORD;
            end
            OP_BRHZ:
            begin
                dec.unit        = UNIT_BRANCH;
                dec.branch_kind = BR_IF_ZERO_HALF;
            end
            OP_BRHNZ:
            begin
                dec.unit        = UNIT_BRANCH;
                dec.branch_kind = BR_IF_NZ_HALF;
            end
            default: dec.unit = UNIT_NONE;
        endcase
    end

    // only the valid bit is cleared, the operand payload just follows issue
    always_ff @(posedge clock)
    begin
        exec <= dec;
        if (reset)
        begin
            exec.valid <= 1'b0;
        end
    end

    // any real opcode must land in one of the two units a cycle later
    a_known_opcode: assert property (@(posedge clock) disable iff (reset)
        issue.valid && issue.opcode != OP_NOP |=> exec.valid && exec.unit != UNIT_NONE);

endmodule

// File: oddpipe_permute.sv
`timescale 1ns/1ps

module oddpipe_permute (
    input  oddpipe_pkg::exec_t exec,
    output oddpipe_pkg::quad_t perm_result
);
    import oddpipe_pkg::*;

    logic [2:0] bit_rot;
    logic [3:0] byte_rot;
    logic [6:0] byte_rot_bits;
    logic [7:0] byte_shl_bits;

    quad_t shl_bits;
    quad_t shl_bytes;
    quad_t rot_bits;
    quad_t rot_bytes;
    quad_t gather_byte;
    quad_t gather_half;
    quad_t gather_word;

    // rotates wrap, so only the low count bits matter
    assign bit_rot       = exec.shift_count[2:0];
    assign byte_rot      = exec.shift_count[3:0];
    assign byte_rot_bits = {byte_rot, 3'b000};
    assign byte_shl_bits = {exec.shift_count, 3'b000};

    // bit 0 is the msb, so moving toward bit 0 is a plain left shift
    assign shl_bits = exec.ra << exec.shift_count;

    // a byte count of 16 or more shifts past 128 bits and leaves zero
    assign shl_bytes = exec.ra << byte_shl_bits;

    // a zero count makes the right shift 128 wide, which yields zero
    assign rot_bits  = (exec.ra << bit_rot) | (exec.ra >> (8'd128 - bit_rot));
    assign rot_bytes = (exec.ra << byte_rot_bits)
                     | (exec.ra >> (8'd128 - byte_rot_bits));

    // gathers collect the lsb of each element into the low end of word 0
    always_comb
    begin
        gather_byte = '0;
        for (int j = 0; j < 16; j++)
        begin
            gather_byte[16 + j] = exec.ra[8 * j + 7];
        end
    end

    always_comb
    begin
        gather_half = '0;
        for (int j = 0; j < 8; j++)
        begin
            gather_half[24 + j] = exec.ra[16 * j + 15];
        end
    end

    always_comb
    begin
        gather_word = '0;
        for (int j = 0; j < 4; j++)
        begin
            gather_word[28 + j] = exec.ra[32 * j + 31];
        end
    end

    always_comb
    begin
        case (exec.perm_mode)
            PERM_SHL_BITS:    perm_result = shl_bits;
            PERM_SHL_BYTES:   perm_result = shl_bytes;
            PERM_ROT_BITS:    perm_result = rot_bits;
            PERM_ROT_BYTES:   perm_result = rot_bytes;
            PERM_GATHER_BYTE: perm_result = gather_byte;
            PERM_GATHER_HALF: perm_result = gather_half;
            PERM_GATHER_WORD: perm_result = gather_word;
            default:          perm_result = '0;
        endcase
    end

endmodule

// File: oddpipe_pkg.sv
package oddpipe_pkg;

    // 128-bit quadword, bit 0 is the most significant
    typedef logic [0:127] quad_t;

    // issued opcodes, nop is zero so an idle bus decodes to nothing
    typedef enum logic [7:0] {
        OP_NOP     = 8'h00,
        // shift left quadword
        OP_SHLQBI  = 8'h01,  // by bits, count in rb
        OP_SHLQBII = 8'h02,  // by bits, immediate
        OP_SHLQBY  = 8'h03,  // by bytes, count in rb
        OP_SHLQBYI = 8'h04,  // by bytes, immediate
        OP_SHLQBYB = 8'h05,  // by bytes from bit shift count
        // rotate quadword
        OP_ROTQBI  = 8'h06,
        OP_ROTQBII = 8'h07,
        OP_ROTQBY  = 8'h08,
        OP_ROTQBYI = 8'h09,
        OP_ROTQBYB = 8'h0A,
        // gather bits
        OP_GBB     = 8'h0B,
        OP_GBH     = 8'h0C,
        OP_GB      = 8'h0D,
        // branches
        OP_BR      = 8'h0E,
        OP_BRA     = 8'h0F,
        OP_BRSL    = 8'h10,
        OP_BRASL   = 8'h11,
        OP_BRZ     = 8'h12,
        OP_BRNZ    = 8'h13,
        OP_BRHZ    = 8'h14,
        OP_BRHNZ   = 8'h15
    } opcode_t;

    typedef enum logic [1:0] {
        UNIT_NONE   = 2'd0,
        UNIT_PERM   = 2'd1,
        UNIT_BRANCH = 2'd2
    } unit_t;

    typedef enum logic [2:0] {
        PERM_SHL_BITS    = 3'd0,
        PERM_SHL_BYTES   = 3'd1,
        PERM_ROT_BITS    = 3'd2,
        PERM_ROT_BYTES   = 3'd3,
        PERM_GATHER_BYTE = 3'd4,
        PERM_GATHER_HALF = 3'd5,
        PERM_GATHER_WORD = 3'd6
    } perm_mode_t;

    typedef enum logic [2:0] {
        BR_ALWAYS       = 3'd0,
        BR_SET_LINK     = 3'd1,
        BR_IF_ZERO_WORD = 3'd2,
        BR_IF_NZ_WORD   = 3'd3,
        BR_IF_ZERO_HALF = 3'd4,
        BR_IF_NZ_HALF   = 3'd5
    } branch_kind_t;

    // instruction as presented on the issue port
    typedef struct packed {
        logic        valid;
        opcode_t     opcode;
        quad_t       ra;
        quad_t       rb;
        logic [0:6]  rt;
        logic [0:6]  i7;
        logic [0:15] i16;
        logic [0:31] pc;
    } issue_t;

    // decoded operation seen by both units
    typedef struct packed {
        logic         valid;
        unit_t        unit;
        perm_mode_t   perm_mode;
        logic [4:0]   shift_count;
        branch_kind_t branch_kind;
        logic         absolute;
        logic [0:31]  disp;         // sign-extended i16, word offset
        quad_t        ra;
        quad_t        rb;
        logic [0:6]   rt;
        logic [0:31]  pc;
    } exec_t;

    // forwarding record, 143 bits
    typedef struct packed {
        logic [0:2] unit_id;
        quad_t      rt_value;
        logic       wr_en;
        logic [0:6] rt;
        logic [0:3] latency;
    } fw_entry_t;

    typedef struct packed {
        logic        taken;
        logic [0:31] target;
    } redirect_t;

    localparam logic [0:2] PERM_UNIT_ID   = 3'd5;
    localparam logic [0:3] PERM_LATENCY   = 4'd4;
    localparam logic [0:2] BRANCH_UNIT_ID = 3'd7;
    localparam logic [0:3] BRANCH_LATENCY = 4'd1;

endpackage

// File: oddpipe_stimulus.txt
# columns: opcode ra rb rt i7 i16 pc | expected rt_value wr_en taken target
# all fields hex, quadwords written word 0 first
01 0123456789abcdeffedcba9876543210 0000000c000000000000000000000000 03 00 0000 00000000 123456789abcdeffedcba98765432100 1 0 00000000
02 800000000000000100000000000000f1 00000000000000000000000000000000 04 0b 0000 00000000 00000000000000080000000000000788 1 0 00000000
03 0123456789abcdeffedcba9876543210 00000003000000000000000000000000 05 00 0000 00000000 6789abcdeffedcba9876543210000000 1 0 00000000
03 0123456789abcdeffedcba9876543210 00000010000000000000000000000000 06 00 0000 00000000 00000000000000000000000000000000 1 0 00000000
04 0123456789abcdeffedcba9876543210 00000000000000000000000000000000 07 25 0000 00000000 abcdeffedcba98765432100000000000 1 0 00000000
04 0123456789abcdeffedcba9876543210 00000000000000000000000000000000 08 12 0000 00000000 00000000000000000000000000000000 1 0 00000000
05 0123456789abcdeffedcba9876543210 00000038000000000000000000000000 09 00 0000 00000000 effedcba987654321000000000000000 1 0 00000000
05 0123456789abcdeffedcba9876543210 00000085000000000000000000000000 0a 00 0000 00000000 00000000000000000000000000000000 1 0 00000000
06 80000000000000000000000000000001 00000009000000000000000000000000 0b 00 0000 00000000 00000000000000000000000000000003 1 0 00000000
07 f00000000000000000000000000000a5 00000000000000000000000000000000 0c 7c 0000 00000000 00000000000000000000000000000a5f 1 0 00000000
06 0123456789abcdeffedcba9876543210 00000008000000000000000000000000 0d 00 0000 00000000 0123456789abcdeffedcba9876543210 1 0 00000000
08 0123456789abcdeffedcba9876543210 00000013000000000000000000000000 0e 00 0000 00000000 6789abcdeffedcba9876543210012345 1 0 00000000
09 0123456789abcdeffedcba9876543210 00000000000000000000000000000000 0f 1a 0000 00000000 ba98765432100123456789abcdeffedc 1 0 00000000
0a 0123456789abcdeffedcba9876543210 000000a8000000000000000000000000 10 00 0000 00000000 abcdeffedcba98765432100123456789 1 0 00000000
0b 01000302fffe11108081000122234445 00000000000000000000000000000000 11 00 0000 00000000 0000aa55000000000000000000000000 1 0 00000000
0c 01000302fffe11108081000122234445 00000000000000000000000000000000 12 00 0000 00000000 0000000f000000000000000000000000 1 0 00000000
0d 0123456789abcdeffedcba9876543210 00000000000000000000000000000000 13 00 0000 00000000 0000000c000000000000000000000000 1 0 00000000
0e 00000000000000000000000000000000 00000000000000000000000000000000 14 00 0010 00001000 00000000000000000000000000000000 0 1 00001040
0e 00000000000000000000000000000000 00000000000000000000000000000000 15 00 fff0 00002000 00000000000000000000000000000000 0 1 00001fc0
0e 00000000000000000000000000000000 00000000000000000000000000000000 16 00 0008 0003fff0 00000000000000000000000000000000 0 1 00000010
0f 00000000000000000000000000000000 00000000000000000000000000000000 17 00 1234 00005000 00000000000000000000000000000000 0 1 000048d0
0f 00000000000000000000000000000000 00000000000000000000000000000000 18 00 8000 00005000 00000000000000000000000000000000 0 1 00020000
10 00000000000000000000000000000000 00000000000000000000000000000000 19 00 0100 00003000 00003004000000000000000000000000 1 1 00003400
11 00000000000000000000000000000000 00000000000000000000000000000000 1a 00 0200 0007fff8 0003fffc000000000000000000000000 1 1 00000800
12 00000000000000000000000000000000 00000000ffffffffffffffffffffffff 1b 00 0004 00001002 00000000000000000000000000000000 0 1 00001010
12 00000000000000000000000000000000 00010000000000000000000000000000 1c 00 0004 00001000 00000000000000000000000000000000 0 0 00001004
13 00000000000000000000000000000000 00010000000000000000000000000000 1d 00 ffff 00004000 00000000000000000000000000000000 0 1 00003ffc
13 00000000000000000000000000000000 00000000ffffffffffffffffffffffff 1e 00 ffff 00004000 00000000000000000000000000000000 0 0 00004004
14 00000000000000000000000000000000 ffff0000000000000000000000000000 1f 00 0020 00006000 00000000000000000000000000000000 0 1 00006080
14 00000000000000000000000000000000 00000001000000000000000000000000 20 00 0020 00006000 00000000000000000000000000000000 0 0 00006004
15 00000000000000000000000000000000 00008000000000000000000000000000 21 00 0001 00007003 00000000000000000000000000000000 0 1 00007004
15 00000000000000000000000000000000 ffff0000000000000000000000000000 22 00 0001 00007003 00000000000000000000000000000000 0 0 00007007
00 0123456789abcdeffedcba9876543210 0123456789abcdeffedcba9876543210 23 7f ffff 00001234 00000000000000000000000000000000 0 0 00000000
00 00000000000000000000000000000000 00000000000000000000000000000000 00 00 0000 00000000 00000000000000000000000000000000 0 0 00000000

// File: oddpipe_top.sv
`timescale 1ns/1ps

module oddpipe_top #(
    parameter logic [0:31] LS_ADDR_MASK = 32'h0003_FFFF,
    parameter int unsigned FW_STAGES    = 7
) (
    input  logic                                  clock,
    input  logic                                  reset,
    input  oddpipe_pkg::issue_t                   issue,
    output oddpipe_pkg::fw_entry_t [1:FW_STAGES]  fw_stages,
    output oddpipe_pkg::redirect_t                redirect
);
    import oddpipe_pkg::*;

    exec_t     exec;
    quad_t     perm_result;
    quad_t     branch_link;
    redirect_t branch_redirect;

    oddpipe_issue i_oddpipe_issue (
        .clock (clock),
        .reset (reset),
        .issue (issue),
        .exec  (exec)
    );

    // both units are combinational off the decoded operation
    oddpipe_permute i_oddpipe_permute (
        .exec        (exec),
        .perm_result (perm_result)
    );

    oddpipe_branch #(
        .LS_ADDR_MASK (LS_ADDR_MASK)
    ) i_oddpipe_branch (
        .exec            (exec),
        .branch_link     (branch_link),
        .branch_redirect (branch_redirect)
    );

    oddpipe_forward #(
        .FW_STAGES (FW_STAGES)
    ) i_oddpipe_forward (
        .clock           (clock),
        .reset           (reset),
        .exec            (exec),
        .perm_result     (perm_result),
        .branch_link     (branch_link),
        .branch_redirect (branch_redirect),
        .fw_stages       (fw_stages),
        .redirect        (redirect)
    );

endmodule

// File: tb_oddpipe.sv
`timescale 1ns/1ps

module tb_oddpipe;
    import oddpipe_pkg::*;

    localparam logic [0:31] LS_ADDR_MASK = 32'h0003_FFFF;
    localparam int unsigned FW_STAGES    = 7;
    localparam int          MAX_LINES    = 64;

    // one expected result, due at the negedge after a given rising edge
    typedef struct packed {
        int        due;
        int        index;
        fw_entry_t entry;
        redirect_t redir;
    } expect_t;

    logic                    clock;
    logic                    reset;
    issue_t                  issue;
    fw_entry_t [1:FW_STAGES] fw_stages;
    redirect_t               redirect;

    issue_t    vec_issue    [MAX_LINES];
    fw_entry_t vec_entry    [MAX_LINES];
    redirect_t vec_redirect [MAX_LINES];
    int        vec_line     [MAX_LINES];
    int        num_lines;
    logic      loaded;

    expect_t   first_q[$];
    expect_t   last_q[$];
    int        edge_count;
    logic      checking;
    logic      failed;
    integer    seed;

    oddpipe_top #(
        .LS_ADDR_MASK (LS_ADDR_MASK),
        .FW_STAGES    (FW_STAGES)
    ) i_oddpipe_top (
        .clock     (clock),
        .reset     (reset),
        .issue     (issue),
        .fw_stages (fw_stages),
        .redirect  (redirect)
    );

    initial
    begin
        clock = 1'b0;
    end

    always #10 clock = ~clock;

    always @(posedge clock)
    begin
        edge_count <= edge_count + 1;
    end

    // record the register file should see, unit id and latency follow the opcode group
    function automatic fw_entry_t expected_entry(opcode_t op, logic [0:6] rt, quad_t value,
                                                 logic wr_en);
        fw_entry_t entry;
        entry = '0;
        if (op >= OP_SHLQBI && op <= OP_GB)
        begin
            entry.unit_id = PERM_UNIT_ID;
            entry.latency = PERM_LATENCY;
        end
        else if (op >= OP_BR && op <= OP_BRHNZ)
        begin
            entry.unit_id = BRANCH_UNIT_ID;
            entry.latency = BRANCH_LATENCY;
        end
        if (op != OP_NOP)
        begin
            entry.rt_value = value;
            entry.wr_en    = wr_en;
            entry.rt       = rt;
        end
        return entry;
    endfunction

    task automatic load_stimulus();
        int          fd;
        int          count;
        int          line_no;
        string       text;
        logic [7:0]  op;
        quad_t       ra;
        quad_t       rb;
        quad_t       value;
        logic [0:6]  rt;
        logic [0:6]  i7;
        logic [0:15] i16;
        logic [0:31] pc;
        logic [0:31] target;
        logic        wr_en;
        logic        taken;
        issue_t      item;
        fd = $fopen("oddpipe_stimulus.txt", "r");
        if (fd == 0)
        begin
            $display("CHECKS FAILED");
            $fatal(1, "could not open oddpipe_stimulus.txt");
        end
        num_lines = 0;
        line_no   = 0;
        while ($fgets(text, fd) > 0)
        begin
            line_no++;
            // skip comments and blank lines
            if (text.len() < 2 || text[0] == "#")
            begin
                continue;
            end
            count = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h",
                            op, ra, rb, rt, i7, i16, pc, value, wr_en, taken, target);
            if (count != 11 || num_lines == MAX_LINES)
            begin
                $display("CHECKS FAILED");
                $fatal(1, "stimulus line %0d is malformed or past the vector limit", line_no);
            end
            item        = '0;
            item.valid  = 1'b1;
            item.opcode = opcode_t'(op);
            item.ra     = ra;
            item.rb     = rb;
            item.rt     = rt;
            item.i7     = i7;
            item.i16    = i16;
            item.pc     = pc;
            vec_issue[num_lines]    = item;
            vec_entry[num_lines]    = expected_entry(opcode_t'(op), rt, value, wr_en);
            vec_redirect[num_lines] = {taken, target};
            vec_line[num_lines]     = line_no;
            num_lines++;
        end
        $fclose(fd);
        if (num_lines == 0)
        begin
            $display("CHECKS FAILED");
            $fatal(1, "the stimulus file holds no vectors");
        end
    endtask

    task automatic check_entry(string name, fw_entry_t expected, fw_entry_t actual);
        if (actual !== expected)
        begin
            failed = 1'b1;
            $display("Fail %s: expected entry %h, actual entry %h", name, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic check_redirect(string name, redirect_t expected, redirect_t actual);
        if (actual !== expected)
        begin
            failed = 1'b1;
            $display("Fail %s: expected taken %b target %h, actual taken %b target %h",
                     name, expected.taken, expected.target, actual.taken, actual.target);
            $display("CHECKS FAILED");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // a stage with nothing due must hold an empty record
    task automatic compare_stage(int stage, logic hit, expect_t item);
        string   name;
        opcode_t op;
        if (hit)
        begin
            op   = vec_issue[item.index].opcode;
            name = $sformatf("line %0d %s stage %0d", vec_line[item.index], op.name(), stage);
        end
        else
        begin
            name = $sformatf("idle stage %0d edge %0d", stage, edge_count);
            item = '0;
        end
        check_entry(name, item.entry, fw_stages[stage]);
        if (stage == 1)
        begin
            check_redirect(name, item.redir, redirect);
        end
    endtask

    always @(negedge clock)
    begin
        expect_t item;
        logic    hit;
        if (checking)
        begin
            item = '0;
            hit  = first_q.size() != 0 && first_q[0].due == edge_count;
            if (hit)
            begin
                item = first_q.pop_front();
            end
            compare_stage(1, hit, item);
            item = '0;
            hit  = last_q.size() != 0 && last_q[0].due == edge_count;
            if (hit)
            begin
                item = last_q.pop_front();
            end
            compare_stage(FW_STAGES, hit, item);
        end
    end

    initial
    begin
        int      idle_cycles;
        int      drive_edge;
        expect_t item;
        reset      = 1'b1;
        issue      = '0;
        edge_count = 0;
        checking   = 1'b0;
        failed     = 1'b0;
        loaded     = 1'b0;
        seed       = 32'habca_3da1;
        load_stimulus();
        loaded = 1'b1;
        repeat (8)
        begin
            @(posedge clock);
        end
        reset    <= 1'b0;
        checking = 1'b1;
        for (int i = 0; i < num_lines; i++)
        begin
            idle_cycles = $unsigned($random(seed)) % 3;
            repeat (idle_cycles)
            begin
                @(posedge clock);
                issue <= '0;
            end
            @(posedge clock);
            issue <= vec_issue[i];
            // edge_count has not counted this edge yet
            drive_edge = edge_count + 1;
            item.index = i;
            item.entry = vec_entry[i];
            item.redir = vec_redirect[i];
            item.due   = drive_edge + 2;
            first_q.push_back(item);
            item.due   = drive_edge + 1 + FW_STAGES;
            last_q.push_back(item);
        end
        @(posedge clock);
        issue <= '0;
        while (last_q.size() != 0)
        begin
            @(posedge clock);
        end
        if (!failed)
        begin
            $display("ALL CHECKS PASSED");
        end
        else
        begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // budget of three cycles per vector plus reset and pipeline drain
    initial
    begin
        wait (loaded === 1'b1);
        repeat (num_lines * 3 + FW_STAGES + 20)
        begin
            @(posedge clock);
        end
        $display("CHECKS FAILED");
        $fatal(1, "timeout, the run did not finish within %0d clock periods",
               num_lines * 3 + FW_STAGES + 20);
    end

endmodule

// File: verilog.f
oddpipe_pkg.sv
oddpipe_issue.sv
oddpipe_permute.sv
oddpipe_branch.sv
oddpipe_forward.sv
oddpipe_top.sv
tb_oddpipe.sv
